//--- verilog/block_looper_defs.svh
/*
 * Block scheduler sizing
 * Offset width, grid dimensions, tile array shape and credit depth
 */
`ifndef BLOCK_LOOPER_DEFS_SVH
`define BLOCK_LOOPER_DEFS_SVH

// Width of every offset, step, end and boundary value
`define BL_OFS_W 16

// Number of grid dimensions
`define BL_VDIM 3

// Axis selector, the value BL_VDIM means no systolic axis
`define BL_AXIS_W $clog2(`BL_VDIM + 1)

// Tile array, tile (i,j) sits at flat index i*BL_TILE_Y + j
`define BL_TILE_X 2
`define BL_TILE_Y 2
`define BL_N_TILE (`BL_TILE_X * `BL_TILE_Y)

// Group size counts 0 up to the larger array side
`define BL_GSIZE_W $clog2(((`BL_TILE_X > `BL_TILE_Y) ? `BL_TILE_X : `BL_TILE_Y) + 1)

// Blocks a tile may hold before it returns a done
`define BL_MAX_PENDING 2

`endif

//--- verilog/block_looper_pkg.sv
/*
 * Block scheduler types
 * Grid configuration, block offset and per-tile job
 */
`include "block_looper_defs.svh"

package block_looper_pkg;

	// One offset per dimension, dimension 0 in the low bits
	typedef logic [`BL_VDIM-1:0][`BL_OFS_W-1:0] blk_ofs_t;

	// Command payload, held by the sender until the command ack
	typedef struct packed {
		blk_ofs_t               step;
		blk_ofs_t               ofs_end;
		blk_ofs_t               boundary;
		logic [`BL_AXIS_W-1:0]  i0_axis;
		logic [`BL_AXIS_W-1:0]  i1_axis;
	} grid_cfg_t;

	// What one tile gets for one block
	typedef struct packed {
		blk_ofs_t               ofs;
		logic [`BL_GSIZE_W-1:0] i0_gsize;
		logic [`BL_GSIZE_W-1:0] i1_gsize;
	} tile_job_t;

endpackage

//--- verilog/grid_offset_counter.sv
/*
 * Grid offset counter
 * Walks the block grid like an odometer, one block per accepted step
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module grid_offset_counter
	import block_looper_pkg::*;
(
	input  logic      i_clk,
	input  logic      i_rst_n,
	input  logic      i_start,
	input  grid_cfg_t i_cfg,
	output logic      o_blk_rdy,
	input  logic      i_blk_ack,
	output blk_ofs_t  o_blk_ofs,
	output logic      o_blk_last
);

	localparam int OFS_W = `BL_OFS_W;
	localparam int VDIM  = `BL_VDIM;

	// FIN holds off a restart while the command is still draining
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_FIN
	} state_t;

	state_t           state;
	blk_ofs_t         ofs_r;
	blk_ofs_t         ofs_nxt;
	logic [OFS_W:0]   ofs_sum [VDIM];
	logic [VDIM-1:0]  wrap;
	logic [VDIM:0]    carry;

	//==========================================================================
	// Next offset
	//==========================================================================
	always_comb begin
		carry[0] = 1'b1;
		for (int k = 0; k < VDIM; k++) begin
			// One extra bit so a large step cannot wrap past end
			ofs_sum[k] = {1'b0, ofs_r[k]} + {1'b0, i_cfg.step[k]};
			wrap[k] = ofs_sum[k] >= {1'b0, i_cfg.ofs_end[k]};
			if (carry[k]) begin
				ofs_nxt[k] = wrap[k] ? '0 : ofs_sum[k][OFS_W-1:0];
			end else begin
				ofs_nxt[k] = ofs_r[k];
			end
			carry[k+1] = carry[k] & wrap[k];
		end
	end

	assign o_blk_rdy  = (state == ST_RUN);
	assign o_blk_ofs  = ofs_r;
	// Every dimension wraps on the final block
	assign o_blk_last = carry[VDIM];

	//==========================================================================
	// Control
	//==========================================================================
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
			ofs_r <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_start) begin
						state <= ST_RUN;
						ofs_r <= '0;
					end
				end
				ST_RUN: begin
					if (i_blk_ack) begin
						if (o_blk_last) begin
							state <= ST_FIN;
						end else begin
							ofs_r <= ofs_nxt;
						end
					end
				end
				default: begin
					// Start drops for a cycle when the command is acked
					if (!i_start) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

//--- verilog/pending_block_counter.sv
/*
 * Pending block counter
 * Credits of blocks handed to one tile and not yet reported done
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module pending_block_counter #(
	parameter int DEPTH = `BL_MAX_PENDING
) (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_inc,
	input  logic i_dec,
	output logic o_full,
	output logic o_empty
);

	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_nxt;

	// A hand-out and a done in the same cycle cancel
	always_comb begin
		case ({i_inc, i_dec})
			2'b10:   cnt_nxt = cnt + 1'b1;
			2'b01:   cnt_nxt = cnt - 1'b1;
			default: cnt_nxt = cnt;
		endcase
	end

	// Flags come from the next count so they line up with cnt
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt     <= '0;
			o_full  <= 1'b0;
			o_empty <= 1'b1;
		end else begin
			cnt     <= cnt_nxt;
			o_full  <= (cnt_nxt == CNT_W'(DEPTH));
			o_empty <= (cnt_nxt == '0);
		end
	end

endmodule

//--- verilog/tile_block_dispatch.sv
/*
 * Tile block dispatcher
 * Fans each block out to the tile array, gates on credits, acks the command
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module tile_block_dispatch
	import block_looper_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  grid_cfg_t             i_cfg,
	input  logic                  i_blk_rdy,
	output logic                  o_blk_ack,
	input  blk_ofs_t              i_blk_ofs,
	input  logic                  i_blk_last,
	input  logic                  i_cmd_rdy,
	output logic                  o_cmd_ack,
	output logic [`BL_N_TILE-1:0] o_tile_rdy,
	input  logic [`BL_N_TILE-1:0] i_tile_ack,
	input  logic [`BL_N_TILE-1:0] i_blk_done,
	output tile_job_t             o_tile_job [`BL_N_TILE]
);

	localparam int OFS_W   = `BL_OFS_W;
	localparam int VDIM    = `BL_VDIM;
	localparam int TX      = `BL_TILE_X;
	localparam int TY      = `BL_TILE_Y;
	localparam int NT      = `BL_N_TILE;
	localparam int GSIZE_W = `BL_GSIZE_W;

	blk_ofs_t             tile_ofs [NT];
	logic [NT-1:0]        tile_valid;
	logic [GSIZE_W-1:0]   i0_gsize;
	logic [GSIZE_W-1:0]   i1_gsize;
	logic [NT-1:0]        taken;
	logic [NT-1:0]        slot_acc;
	logic [NT-1:0]        slot_done;
	logic [NT-1:0]        job_vld;
	logic [NT-1:0]        tile_xfer;
	logic [NT-1:0]        pend_full;
	logic [NT-1:0]        pend_empty;
	logic                 last_acc;

	//==========================================================================
	// Tile offsets and validity
	//==========================================================================
	always_comb begin
		for (int i = 0; i < TX; i++) begin
			for (int j = 0; j < TY; j++) begin
				tile_valid[i*TY+j] = 1'b1;
				for (int k = 0; k < VDIM; k++) begin
					// i0 wins if both axes name the same dimension
					if (k == i_cfg.i0_axis) begin
						tile_ofs[i*TY+j][k] = OFS_W'(i_blk_ofs[k] * TX + i * i_cfg.step[k]);
					end else if (k == i_cfg.i1_axis) begin
						tile_ofs[i*TY+j][k] = OFS_W'(i_blk_ofs[k] * TY + j * i_cfg.step[k]);
					end else begin
						tile_ofs[i*TY+j][k] = i_blk_ofs[k];
					end
					if (tile_ofs[i*TY+j][k] >= i_cfg.boundary[k]) begin
						tile_valid[i*TY+j] = 1'b0;
					end
				end
			end
		end
	end

	// Valid tiles in column 0 along X and in row 0 along Y
	always_comb begin
		i0_gsize = '0;
		i1_gsize = '0;
		for (int i = 0; i < TX; i++) begin
			i0_gsize = i0_gsize + GSIZE_W'(tile_valid[i*TY]);
		end
		for (int j = 0; j < TY; j++) begin
			i1_gsize = i1_gsize + GSIZE_W'(tile_valid[j]);
		end
	end

	//==========================================================================
	// Handshakes
	//==========================================================================
	// A full credit counter holds the registered job back from the tile
	assign o_tile_rdy = job_vld & ~pend_full;
	assign tile_xfer  = o_tile_rdy & i_tile_ack;

	// The output register takes a new job when empty or emptying this cycle
	assign slot_acc  = {NT{i_blk_rdy}} & tile_valid & ~taken & (~job_vld | tile_xfer);
	// Invalid tiles count as taken right away
	assign slot_done = taken | slot_acc | ~tile_valid;
	assign o_blk_ack = i_blk_rdy & (&slot_done);

	assign o_cmd_ack = i_cmd_rdy & last_acc & (&pend_empty) & ~(|o_tile_rdy);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			job_vld  <= '0;
			taken    <= '0;
			last_acc <= 1'b0;
		end else begin
			job_vld <= (job_vld & ~tile_xfer) | slot_acc;
			if (o_blk_ack) begin
				taken <= '0;
			end else begin
				taken <= taken | slot_acc;
			end
			if (o_cmd_ack) begin
				last_acc <= 1'b0;
			end else if (o_blk_ack && i_blk_last) begin
				last_acc <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		for (int t = 0; t < NT; t++) begin
			if (slot_acc[t]) begin
				o_tile_job[t].ofs      <= tile_ofs[t];
				o_tile_job[t].i0_gsize <= i0_gsize;
				o_tile_job[t].i1_gsize <= i1_gsize;
			end
		end
	end

	//==========================================================================
	// Credits
	//==========================================================================
	for (genvar gt = 0; gt < NT; gt++) begin : g_pend
		pending_block_counter #(
			.DEPTH(`BL_MAX_PENDING)
		) u_pend (
			.i_clk   (i_clk),
			.i_rst_n (i_rst_n),
			.i_inc   (tile_xfer[gt]),
			.i_dec   (i_blk_done[gt]),
			.o_full  (pend_full[gt]),
			.o_empty (pend_empty[gt])
		);
	end

endmodule

//--- verilog/block_looper_top.sv
/*
 * Block looper top
 * Command port, grid counter and tile dispatcher of the compute array
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module block_looper_top
	import block_looper_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_cmd_rdy,
	input  grid_cfg_t             i_cmd_cfg,
	output logic                  o_cmd_ack,
	output logic [`BL_N_TILE-1:0] o_tile_rdy,
	input  logic [`BL_N_TILE-1:0] i_tile_ack,
	output tile_job_t             o_tile_job [`BL_N_TILE],
	input  logic [`BL_N_TILE-1:0] i_blk_done
);

	logic     blk_rdy;
	logic     blk_ack;
	blk_ofs_t blk_ofs;
	logic     blk_last;

	// Start drops in the ack cycle so a back-to-back command restarts the walk
	grid_offset_counter u_cnt (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_start    (i_cmd_rdy & ~o_cmd_ack),
		.i_cfg      (i_cmd_cfg),
		.o_blk_rdy  (blk_rdy),
		.i_blk_ack  (blk_ack),
		.o_blk_ofs  (blk_ofs),
		.o_blk_last (blk_last)
	);

	tile_block_dispatch u_dsp (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cfg      (i_cmd_cfg),
		.i_blk_rdy  (blk_rdy),
		.o_blk_ack  (blk_ack),
		.i_blk_ofs  (blk_ofs),
		.i_blk_last (blk_last),
		.i_cmd_rdy  (i_cmd_rdy),
		.o_cmd_ack  (o_cmd_ack),
		.o_tile_rdy (o_tile_rdy),
		.i_tile_ack (i_tile_ack),
		.i_blk_done (i_blk_done),
		.o_tile_job (o_tile_job)
	);

endmodule

//--- testbench/block_looper_assert.sv
/*
 * Block looper assertions
 * Command ack pulse, tile handshake rules and the command ack against busy tiles
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module block_looper_assert
	import block_looper_pkg::*;
(
	input logic                  i_clk,
	input logic                  i_rst_n,
	input logic                  o_cmd_ack,
	input logic [`BL_N_TILE-1:0] o_tile_rdy,
	input logic [`BL_N_TILE-1:0] i_tile_ack,
	input tile_job_t             o_tile_job [`BL_N_TILE]
);

	// Failures seen so far, read back by the testbench
	int fail_cnt = 0;

	a_cmd_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_ack |=> !o_cmd_ack)
		else begin
			fail_cnt++;
			$error("command ack held for more than one cycle");
		end

	// No job waiting or handed over in the cycle before the command ack
	a_ack_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_cmd_ack |-> !$past(|o_tile_rdy))
		else begin
			fail_cnt++;
			$error("command ack right after a tile job was waiting");
		end

	for (genvar t = 0; t < `BL_N_TILE; t++) begin : g_tile
		a_rdy_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
			o_tile_rdy[t] && !i_tile_ack[t] |=> o_tile_rdy[t])
			else begin
				fail_cnt++;
				$error("tile %0d dropped rdy before ack", t);
			end
		a_job_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
			o_tile_rdy[t] && !i_tile_ack[t] |=> $stable(o_tile_job[t]))
			else begin
				fail_cnt++;
				$error("tile %0d job changed while waiting", t);
			end
	end

endmodule

bind block_looper_top block_looper_assert u_assert (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.o_cmd_ack  (o_cmd_ack),
	.o_tile_rdy (o_tile_rdy),
	.i_tile_ack (i_tile_ack),
	.o_tile_job (o_tile_job)
);

//--- testbench/block_looper_tb.sv
/*
 * Block looper testbench
 * Tile models, in-order job reference and directed command tests
 */
`timescale 1ns/1ps
`include "block_looper_defs.svh"

module block_looper_tb
	import block_looper_pkg::*;
;

	localparam int NT = `BL_N_TILE;
	localparam int TY = `BL_TILE_Y;
	localparam int VDIM = `BL_VDIM;
	localparam int OFS_W = `BL_OFS_W;
	localparam int AXIS_W = `BL_AXIS_W;
	localparam int GSIZE_W = `BL_GSIZE_W;
	localparam int CLK_PERIOD = 10;
	localparam int N_TESTS = 5;

	logic            i_clk = 1'b0;
	logic            i_rst_n;
	logic            i_cmd_rdy;
	grid_cfg_t       i_cmd_cfg;
	logic            o_cmd_ack;
	logic [NT-1:0]   o_tile_rdy;
	logic [NT-1:0]   i_tile_ack;
	tile_job_t       o_tile_job [NT];
	logic [NT-1:0]   i_blk_done;

	int seed = 32'h8b42;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int ack_cnt = 0;
	int ack_pct [NT];
	bit done_en;
	tile_job_t exp_mem [NT][64];
	int exp_n [NT];
	int got_n [NT];
	int held [NT];
	int held_sum;

	block_looper_top block_looper_top_i (.*);

	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	//==========================================================================
	// Compare tasks and helpers
	//==========================================================================
	task automatic check_job(string name, tile_job_t got, tile_job_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH t=%0t %s got %0d exp %0d", $time, name, got, exp);
		end
	endtask

	function automatic bit roll(int pct);
		roll = ($unsigned($random(seed)) % 100) < pct;
	endfunction

	function automatic blk_ofs_t ofs3(int d0, int d1, int d2);
		blk_ofs_t r;
		r[0] = OFS_W'(d0);
		r[1] = OFS_W'(d1);
		r[2] = OFS_W'(d2);
		return r;
	endfunction

	function automatic grid_cfg_t make_cfg(blk_ofs_t st, blk_ofs_t e, blk_ofs_t bnd,
		int a0, int a1);
		grid_cfg_t c;
		c.step = st;
		c.ofs_end = e;
		c.boundary = bnd;
		c.i0_axis = AXIS_W'(a0);
		c.i1_axis = AXIS_W'(a1);
		return c;
	endfunction

	// Expected jobs per tile, block by block with dimension 0 fastest
	task automatic build_expected(grid_cfg_t cfg);
		int b [VDIM];
		int o;
		int g0;
		int g1;
		bit carry;
		bit valid [NT];
		blk_ofs_t ofs [NT];
		for (int t = 0; t < NT; t++) exp_n[t] = 0;
		for (int k = 0; k < VDIM; k++) b[k] = 0;
		carry = 1'b0;
		while (!carry) begin
			for (int t = 0; t < NT; t++) begin
				valid[t] = 1'b1;
				for (int k = 0; k < VDIM; k++) begin
					if (k == cfg.i0_axis) o = b[k] * `BL_TILE_X + (t / TY) * cfg.step[k];
					else if (k == cfg.i1_axis) o = b[k] * TY + (t % TY) * cfg.step[k];
					else o = b[k];
					ofs[t][k] = OFS_W'(o);
					if (ofs[t][k] >= cfg.boundary[k]) valid[t] = 1'b0;
				end
			end
			g0 = 0;
			g1 = 0;
			for (int i = 0; i < `BL_TILE_X; i++) g0 += valid[i * TY];
			for (int j = 0; j < TY; j++) g1 += valid[j];
			for (int t = 0; t < NT; t++) begin
				if (valid[t]) begin
					exp_mem[t][exp_n[t]].ofs = ofs[t];
					exp_mem[t][exp_n[t]].i0_gsize = GSIZE_W'(g0);
					exp_mem[t][exp_n[t]].i1_gsize = GSIZE_W'(g1);
					exp_n[t]++;
				end
			end
			// Odometer step, carry out of the top dimension ends the grid
			carry = 1'b1;
			for (int k = 0; k < VDIM && carry; k++) begin
				if (b[k] + cfg.step[k] >= cfg.ofs_end[k]) begin
					b[k] = 0;
				end else begin
					b[k] += cfg.step[k];
					carry = 1'b0;
				end
			end
		end
	endtask

	//==========================================================================
	// Tile models
	//==========================================================================
	always @(posedge i_clk) begin
		if (!i_rst_n) begin
			i_tile_ack <= '0;
			i_blk_done <= '0;
			for (int t = 0; t < NT; t++) held[t] = 0;
		end else begin
			held_sum = 0;
			for (int t = 0; t < NT; t++) held_sum += held[t];
			if (o_cmd_ack) begin
				ack_cnt++;
				check_count("blocks outstanding at o_cmd_ack", held_sum, 0);
			end
			for (int t = 0; t < NT; t++) begin
				if (o_tile_rdy[t] && i_tile_ack[t]) begin
					held[t]++;
					if (got_n[t] >= exp_n[t]) begin
						errors++;
						$display("Tile %0d got a job beyond its expected sequence", t);
					end else begin
						check_job($sformatf("o_tile_job[%0d]", t), o_tile_job[t],
							exp_mem[t][got_n[t]]);
					end
					got_n[t]++;
				end
				if (held[t] > `BL_MAX_PENDING) begin
					errors++;
					$display("Tile %0d holds %0d blocks, over its credit limit", t, held[t]);
				end
				i_tile_ack[t] <= roll(ack_pct[t]);
				if (done_en && held[t] > 0 && roll(50)) begin
					i_blk_done[t] <= 1'b1;
					held[t]--;
				end else begin
					i_blk_done[t] <= 1'b0;
				end
			end
		end
	end

	//==========================================================================
	// Test tasks
	//==========================================================================
	task automatic set_tiles(int pct, bit dones);
		for (int t = 0; t < NT; t++) ack_pct[t] = pct;
		done_en = dones;
	endtask

	task automatic apply_reset();
		@(posedge i_clk);
		i_rst_n <= 1'b0;
		repeat (8) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(posedge i_clk);
		check_count("o_cmd_ack after reset", o_cmd_ack, 0);
		check_count("o_tile_rdy after reset", o_tile_rdy, 0);
	endtask

	task automatic start_cmd(grid_cfg_t cfg);
		build_expected(cfg);
		for (int t = 0; t < NT; t++) got_n[t] = 0;
		ack_cnt = 0;
		@(posedge i_clk);
		i_cmd_cfg <= cfg;
		i_cmd_rdy <= 1'b1;
	endtask

	// Watchdog bounds this wait
	task automatic finish_cmd();
		do @(posedge i_clk); while (!o_cmd_ack);
		i_cmd_rdy <= 1'b0;
		repeat (4) @(posedge i_clk);
		check_count("o_cmd_ack pulses", ack_cnt, 1);
		for (int t = 0; t < NT; t++) begin
			check_count($sformatf("jobs on tile %0d", t), got_n[t], exp_n[t]);
		end
	endtask

	task automatic end_test(string name, int err0);
		tests++;
		$display("test %-12s %s, %0d errors", name,
			(errors == err0) ? "ok" : "failed", errors - err0);
	endtask

	task automatic test_full_grid();
		int err0 = errors;
		set_tiles(100, 1'b1);
		start_cmd(make_cfg(ofs3(1, 1, 1), ofs3(2, 2, 1), ofs3(100, 100, 100), 0, 1));
		finish_cmd();
		end_test("full_grid", err0);
	endtask

	// Tiles with i=1 land on offset 5 in the last block of dimension 0
	task automatic test_clipping();
		int err0 = errors;
		set_tiles(80, 1'b1);
		start_cmd(make_cfg(ofs3(1, 1, 1), ofs3(3, 1, 1), ofs3(5, 100, 100), 0, 1));
		finish_cmd();
		end_test("clipping", err0);
	endtask

	task automatic test_backpressure();
		int err0 = errors;
		set_tiles(90, 1'b1);
		ack_pct[2] = 25;
		start_cmd(make_cfg(ofs3(1, 1, 1), ofs3(3, 2, 2), ofs3(100, 100, 100), 0, 1));
		finish_cmd();
		end_test("backpressure", err0);
	endtask

	task automatic test_credit_limit();
		int err0 = errors;
		set_tiles(100, 1'b0);
		start_cmd(make_cfg(ofs3(1, 1, 1), ofs3(2, 2, 1), ofs3(100, 100, 100), 0, 1));
		// Long enough for any further job to show up
		repeat (40) @(posedge i_clk);
		for (int t = 0; t < NT; t++) begin
			check_count($sformatf("jobs on tile %0d with no dones", t), got_n[t],
				`BL_MAX_PENDING);
		end
		check_count("o_cmd_ack pulses with no dones", ack_cnt, 0);
		done_en = 1'b1;
		finish_cmd();
		end_test("credit_limit", err0);
	endtask

	task automatic test_completion();
		int err0 = errors;
		set_tiles(70, 1'b1);
		apply_reset();
		start_cmd(make_cfg(ofs3(1, 1, 1), ofs3(2, 1, 1), ofs3(100, 100, 100), 0, 1));
		finish_cmd();
		start_cmd(make_cfg(ofs3(1, 2, 1), ofs3(2, 4, 2), ofs3(100, 100, 3), 2, 0));
		finish_cmd();
		end_test("completion", err0);
	endtask

	//==========================================================================
	// Main sequence and watchdog
	//==========================================================================
	initial begin
		i_rst_n = 1'b0;
		i_cmd_rdy = 1'b0;
		i_cmd_cfg = '0;
		i_tile_ack = '0;
		i_blk_done = '0;
		done_en = 1'b0;
		for (int t = 0; t < NT; t++) begin
			ack_pct[t] = 0;
			exp_n[t] = 0;
			got_n[t] = 0;
		end
		apply_reset();
		test_full_grid();
		test_clipping();
		test_backpressure();
		test_credit_limit();
		test_completion();
		errors += block_looper_top_i.u_assert.fail_cnt;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(N_TESTS * 2000 * CLK_PERIOD);
		$display("Timeout, a command never completed");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

//--- compile.f
+incdir+verilog
verilog/block_looper_pkg.sv
verilog/grid_offset_counter.sv
verilog/pending_block_counter.sv
verilog/tile_block_dispatch.sv
verilog/block_looper_top.sv
testbench/block_looper_assert.sv
testbench/block_looper_tb.sv
